// File: logic/rab_cfg_pkg.sv
`default_nettype none

package rab_cfg_pkg;

  // ----------------------------------------
  // Request field widths
  // ----------------------------------------
  localparam int ADDR_WIDTH = 32;
  localparam int ID_WIDTH   = 4;
  // Beats minus one, AXI style
  localparam int LEN_WIDTH  = 8;

  // ----------------------------------------
  // Translation table and buffering
  // ----------------------------------------
  localparam int NUM_SLICES_DEFAULT = 4;
  localparam int REQ_DEPTH_DEFAULT  = 16;
  localparam int MISS_DEPTH_DEFAULT = 8;

  // ----------------------------------------
  // Beat and page geometry
  // ----------------------------------------
  // All requests are beat aligned
  localparam int BEAT_BYTES = 8;
  // Bursts never cross this boundary on the master side
  localparam int PAGE_BYTES = 4096;
  localparam int BEAT_BITS  = $clog2(BEAT_BYTES);
  localparam int PAGE_BITS  = $clog2(PAGE_BYTES);
  localparam int PAGE_BEATS = PAGE_BYTES / BEAT_BYTES;

endpackage

`default_nettype wire

// File: logic/rab_types_pkg.sv
`default_nettype none

package rab_types_pkg;

  // ----------------------------------------
  // Address request, hit side
  // ----------------------------------------
  // Address is virtual before the lookup and physical after it
  typedef struct packed {
    logic [rab_cfg_pkg::ADDR_WIDTH-1:0] addr;
    logic [rab_cfg_pkg::ID_WIDTH-1:0]   id;
    logic [rab_cfg_pkg::LEN_WIDTH-1:0]  len;
  } rab_req_t;

  // ----------------------------------------
  // Miss report
  // ----------------------------------------
  // Untranslated address as it arrived on the slave side
  typedef struct packed {
    logic [rab_cfg_pkg::ADDR_WIDTH-1:0] addr;
    logic [rab_cfg_pkg::ID_WIDTH-1:0]   id;
  } rab_miss_t;

endpackage

`default_nettype wire

// File: logic/rab_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// Valid/ready stream between blocks of the address path
// Transfer on a rising edge with valid and ready both high
interface rab_stream_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t data;

  // Sending side, holds valid and data until the transfer
  modport src (
    output valid,
    output data,
    input  ready
  );

  // Receiving side
  modport dst (
    input  valid,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// File: logic/rab_bram.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port RAM for block RAM inference
// One write port, one read port with registered output
module rab_bram #(
  parameter int  ADDR_BITS = 4,
  parameter type word_t    = logic
) (
  input  logic                 clk,
  input  logic                 we,
  input  logic [ADDR_BITS-1:0] waddr,
  input  word_t                wdata,
  input  logic [ADDR_BITS-1:0] raddr,
  output word_t                rdata
);

  localparam int WORDS = 2 ** ADDR_BITS;

  word_t mem [WORDS];

  // Write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, old word returned on a same-address collision
  always_ff @(posedge clk)
  begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: logic/rab_fifo_bram.sv
`timescale 1ns/1ps
`default_nettype none

// First-word fall-through FIFO on top of a registered-read RAM
module rab_fifo_bram #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic
) (
  input  logic      clk,
  input  logic      rstn,
  input  logic      flush,
  rab_stream_if.dst wr,
  rab_stream_if.src rd
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
  localparam logic [PTR_BITS:0]   FULL_CNT = (PTR_BITS + 1)'(DEPTH);

  // Slot written next
  logic [PTR_BITS-1:0] wr_ptr;
  // Slot currently presented on rd
  logic [PTR_BITS-1:0] rd_ptr;
  // Slot presented after this edge, fed to the RAM one cycle early
  logic [PTR_BITS-1:0] rd_ptr_bram;
  logic [PTR_BITS:0]   count;

  logic     full;
  logic     push;
  logic     pop;
  logic     collide;
  logic     bypass_sel;
  payload_t bypass_q;
  payload_t ram_rdata;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  assign full     = (count == FULL_CNT);
  assign wr.ready = !full;
  assign rd.valid = (count != '0);
  assign push     = wr.valid && !full;
  assign pop      = rd.valid && rd.ready;

  // Look ahead so the RAM output is already on the next slot
  assign rd_ptr_bram = pop ? ptr_inc(rd_ptr) : rd_ptr;

  // Fill level, flush drops a write arriving in the same cycle too
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      count <= '0;
    end
    else if (flush)
    begin
      count <= '0;
    end
    else if (push && !pop)
    begin
      count <= count + 1'b1;
    end
    else if (pop && !push)
    begin
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else if (flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      rd_ptr <= rd_ptr_bram;
    end
  end

  // ----------------------------------------
  // Read-during-write bypass
  // ----------------------------------------
  // RAM returns the old word when the slot being read is written
  // Covers a write into an empty FIFO and a pop onto the newest slot
  assign collide = push && (wr_ptr == rd_ptr_bram);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      bypass_sel <= 1'b0;
    end
    else if (flush)
    begin
      bypass_sel <= 1'b0;
    end
    else
    begin
      // One cycle only, the RAM holds the word from then on
      bypass_sel <= collide;
    end
  end

  always_ff @(posedge clk)
  begin
    if (collide)
    begin
      bypass_q <= wr.data;
    end
  end

  assign rd.data = bypass_sel ? bypass_q : ram_rdata;

  rab_bram #(
    .ADDR_BITS ( PTR_BITS  ),
    .word_t    ( payload_t )
  ) i_bram (
    .clk   ( clk         ),
    .we    ( push        ),
    .waddr ( wr_ptr      ),
    .wdata ( wr.data     ),
    .raddr ( rd_ptr_bram ),
    .rdata ( ram_rdata   )
  );

endmodule

`default_nettype wire

// File: logic/rab_slice_lookup.sv
`timescale 1ns/1ps
`default_nettype none

// Slice table lookup with one output register stage
module rab_slice_lookup #(
  parameter int NUM_SLICES = rab_cfg_pkg::NUM_SLICES_DEFAULT,
  localparam int IDX_BITS  = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1
) (
  input  logic                                clk,
  input  logic                                rstn,
  // Configuration write port
  input  logic                                cfg_we,
  input  logic [IDX_BITS-1:0]                 cfg_idx,
  input  logic                                cfg_en,
  input  logic [rab_cfg_pkg::ADDR_WIDTH-1:0]  cfg_first,
  input  logic [rab_cfg_pkg::ADDR_WIDTH-1:0]  cfg_last,
  input  logic [rab_cfg_pkg::ADDR_WIDTH-1:0]  cfg_phys,
  // Slave-side request
  input  logic                                in_valid,
  input  logic [rab_cfg_pkg::ADDR_WIDTH-1:0]  in_addr,
  input  logic [rab_cfg_pkg::ID_WIDTH-1:0]    in_id,
  input  logic [rab_cfg_pkg::LEN_WIDTH-1:0]   in_len,
  output logic                                in_ready,
  rab_stream_if.src                           hit,
  rab_stream_if.src                           miss
);

  localparam int AW = rab_cfg_pkg::ADDR_WIDTH;

  // Slice table
  logic          slice_en    [NUM_SLICES];
  logic [AW-1:0] slice_first [NUM_SLICES];
  logic [AW-1:0] slice_last  [NUM_SLICES];
  logic [AW-1:0] slice_phys  [NUM_SLICES];

  logic          found;
  logic [AW-1:0] sel_first;
  logic [AW-1:0] sel_phys;
  logic [AW-1:0] phys_addr;

  logic                    stage_valid;
  logic                    stage_hit;
  rab_types_pkg::rab_req_t stage_req;
  logic                    stage_take;
  logic                    accept;

  // ----------------------------------------
  // Configuration
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      for (int i = 0; i < NUM_SLICES; i++)
      begin
        slice_en[i] <= 1'b0;
      end
    end
    else if (cfg_we)
    begin
      slice_en[cfg_idx] <= cfg_en;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cfg_we)
    begin
      slice_first[cfg_idx] <= cfg_first;
      slice_last[cfg_idx]  <= cfg_last;
      slice_phys[cfg_idx]  <= cfg_phys;
    end
  end

  // ----------------------------------------
  // Match, lowest enabled index wins
  // ----------------------------------------
  always_comb
  begin
    found     = 1'b0;
    sel_first = '0;
    sel_phys  = '0;
    for (int i = 0; i < NUM_SLICES; i++)
    begin
      if (!found && slice_en[i] && (in_addr >= slice_first[i]) &&
          (in_addr <= slice_last[i]))
      begin
        found     = 1'b1;
        sel_first = slice_first[i];
        sel_phys  = slice_phys[i];
      end
    end
  end

  // Base plus offset into the slice
  assign phys_addr = sel_phys + (in_addr - sel_first);

  // ----------------------------------------
  // Output stage
  // ----------------------------------------
  // Stage drains only into the stream it targets, keeping input order
  assign stage_take = stage_hit ? hit.ready : miss.ready;
  assign in_ready   = !stage_valid || stage_take;
  assign accept     = in_valid && in_ready;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      stage_valid <= 1'b0;
    end
    else if (accept)
    begin
      stage_valid <= 1'b1;
    end
    else if (stage_take)
    begin
      stage_valid <= 1'b0;
    end
  end

  // Misses keep the original address
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      stage_hit      <= found;
      stage_req.addr <= found ? phys_addr : in_addr;
      stage_req.id   <= in_id;
      stage_req.len  <= in_len;
    end
  end

  assign hit.valid  = stage_valid && stage_hit;
  assign hit.data   = stage_req;
  assign miss.valid = stage_valid && !stage_hit;
  assign miss.data  = rab_types_pkg::rab_miss_t'{addr: stage_req.addr, id: stage_req.id};

endmodule

`default_nettype wire

// File: logic/rab_burst_split.sv
`timescale 1ns/1ps
`default_nettype none

// Cuts translated bursts at page boundaries, one piece per cycle
module rab_burst_split (
  input  logic                               clk,
  input  logic                               rstn,
  rab_stream_if.dst                          in,
  output logic                               m_valid,
  output logic [rab_cfg_pkg::ADDR_WIDTH-1:0] m_addr,
  output logic [rab_cfg_pkg::ID_WIDTH-1:0]   m_id,
  output logic [rab_cfg_pkg::LEN_WIDTH-1:0]  m_len,
  input  logic                               m_ready
);

  localparam int AW        = rab_cfg_pkg::ADDR_WIDTH;
  localparam int LW        = rab_cfg_pkg::LEN_WIDTH;
  localparam int BEAT_BITS = rab_cfg_pkg::BEAT_BITS;
  localparam int PAGE_BITS = rab_cfg_pkg::PAGE_BITS;
  localparam int OFFS_BITS = PAGE_BITS - BEAT_BITS;
  // Wide enough for a full burst and for a full page in beats
  localparam int CNT_BITS  = (LW > OFFS_BITS) ? LW + 1 : OFFS_BITS + 1;

  logic                              busy;
  logic [AW-1:0]                     cur_addr;
  logic [CNT_BITS-1:0]               beats_left;
  logic [rab_cfg_pkg::ID_WIDTH-1:0]  cur_id;

  logic [CNT_BITS-1:0] room;
  logic [CNT_BITS-1:0] piece_beats;
  logic [CNT_BITS-1:0] piece_len;
  logic [AW-1:0]       piece_bytes;
  logic                last_piece;
  logic                issue;
  logic                load;

  // ----------------------------------------
  // Current piece
  // ----------------------------------------
  // Beats until the next page boundary
  assign room = CNT_BITS'(rab_cfg_pkg::PAGE_BEATS) -
                CNT_BITS'(cur_addr[PAGE_BITS-1:BEAT_BITS]);

  assign piece_beats = (beats_left < room) ? beats_left : room;
  assign piece_len   = piece_beats - 1'b1;
  assign piece_bytes = AW'(piece_beats) << BEAT_BITS;
  assign last_piece  = (piece_beats == beats_left);

  assign m_valid = busy;
  assign m_addr  = cur_addr;
  assign m_id    = cur_id;
  assign m_len   = piece_len[LW-1:0];

  assign issue = busy && m_ready;

  // Reload on the last piece, so bursts follow without a gap
  assign in.ready = !busy || (m_ready && last_piece);
  assign load     = in.valid && in.ready;

  // ----------------------------------------
  // Burst state
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      busy <= 1'b0;
    end
    else if (load)
    begin
      busy <= 1'b1;
    end
    else if (issue && last_piece)
    begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      cur_addr   <= in.data.addr;
      cur_id     <= in.data.id;
      beats_left <= CNT_BITS'(in.data.len) + 1'b1;
    end
    else if (issue)
    begin
      // Step to the start of the next page
      cur_addr   <= cur_addr + piece_bytes;
      beats_left <= beats_left - piece_beats;
    end
  end

endmodule

`default_nettype wire

// File: logic/rab_addr_path.sv
`timescale 1ns/1ps
`default_nettype none

// RAB address path, lookup then request FIFO then splitter
// Misses leave through their own FIFO
module rab_addr_path #(
  parameter int NUM_SLICES = rab_cfg_pkg::NUM_SLICES_DEFAULT,
  parameter int REQ_DEPTH  = rab_cfg_pkg::REQ_DEPTH_DEFAULT,
  parameter int MISS_DEPTH = rab_cfg_pkg::MISS_DEPTH_DEFAULT,
  localparam int IDX_BITS  = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1
) (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               flush,
  // Configuration
  input  logic                               cfg_we,
  input  logic [IDX_BITS-1:0]                cfg_idx,
  input  logic                               cfg_en,
  input  logic [rab_cfg_pkg::ADDR_WIDTH-1:0] cfg_first,
  input  logic [rab_cfg_pkg::ADDR_WIDTH-1:0] cfg_last,
  input  logic [rab_cfg_pkg::ADDR_WIDTH-1:0] cfg_phys,
  // Slave side
  input  logic                               in_valid,
  input  logic [rab_cfg_pkg::ADDR_WIDTH-1:0] in_addr,
  input  logic [rab_cfg_pkg::ID_WIDTH-1:0]   in_id,
  input  logic [rab_cfg_pkg::LEN_WIDTH-1:0]  in_len,
  output logic                               in_ready,
  // Master side
  output logic                               m_valid,
  output logic [rab_cfg_pkg::ADDR_WIDTH-1:0] m_addr,
  output logic [rab_cfg_pkg::ID_WIDTH-1:0]   m_id,
  output logic [rab_cfg_pkg::LEN_WIDTH-1:0]  m_len,
  input  logic                               m_ready,
  // Miss port
  output logic                               miss_valid,
  output logic [rab_cfg_pkg::ADDR_WIDTH-1:0] miss_addr,
  output logic [rab_cfg_pkg::ID_WIDTH-1:0]   miss_id,
  input  logic                               miss_ready
);

  rab_stream_if #(.payload_t(rab_types_pkg::rab_req_t))  lookup_to_req  ();
  rab_stream_if #(.payload_t(rab_types_pkg::rab_miss_t)) lookup_to_miss ();
  rab_stream_if #(.payload_t(rab_types_pkg::rab_req_t))  req_to_split   ();
  rab_stream_if #(.payload_t(rab_types_pkg::rab_miss_t)) miss_to_out    ();

  // ----------------------------------------
  // Translation
  // ----------------------------------------
  rab_slice_lookup #(
    .NUM_SLICES ( NUM_SLICES )
  ) i_lookup (
    .clk       ( clk            ),
    .rstn      ( rstn           ),
    .cfg_we    ( cfg_we         ),
    .cfg_idx   ( cfg_idx        ),
    .cfg_en    ( cfg_en         ),
    .cfg_first ( cfg_first      ),
    .cfg_last  ( cfg_last       ),
    .cfg_phys  ( cfg_phys       ),
    .in_valid  ( in_valid       ),
    .in_addr   ( in_addr        ),
    .in_id     ( in_id          ),
    .in_len    ( in_len         ),
    .in_ready  ( in_ready       ),
    .hit       ( lookup_to_req  ),
    .miss      ( lookup_to_miss )
  );

  // ----------------------------------------
  // Buffering
  // ----------------------------------------
  rab_fifo_bram #(
    .DEPTH     ( REQ_DEPTH                ),
    .payload_t ( rab_types_pkg::rab_req_t )
  ) i_req_fifo (
    .clk   ( clk           ),
    .rstn  ( rstn          ),
    .flush ( flush         ),
    .wr    ( lookup_to_req ),
    .rd    ( req_to_split  )
  );

  rab_fifo_bram #(
    .DEPTH     ( MISS_DEPTH                ),
    .payload_t ( rab_types_pkg::rab_miss_t )
  ) i_miss_fifo (
    .clk   ( clk            ),
    .rstn  ( rstn           ),
    .flush ( flush          ),
    .wr    ( lookup_to_miss ),
    .rd    ( miss_to_out    )
  );

  // ----------------------------------------
  // Master side issue
  // ----------------------------------------
  rab_burst_split i_split (
    .clk     ( clk          ),
    .rstn    ( rstn         ),
    .in      ( req_to_split ),
    .m_valid ( m_valid      ),
    .m_addr  ( m_addr       ),
    .m_id    ( m_id         ),
    .m_len   ( m_len        ),
    .m_ready ( m_ready      )
  );

  // Miss FIFO drains straight to the ports
  assign miss_valid        = miss_to_out.valid;
  assign miss_addr         = miss_to_out.data.addr;
  assign miss_id           = miss_to_out.data.id;
  assign miss_to_out.ready = miss_ready;

endmodule

`default_nettype wire

// File: tb/tb_rab_ref.svh
`ifndef TB_RAB_REF_SVH
`define TB_RAB_REF_SVH

// ----------------------------------------
// Reference model of the address path
// ----------------------------------------

// Testbench copy of the slice table
logic        ref_en    [NUM_SLICES];
logic [31:0] ref_first [NUM_SLICES];
logic [31:0] ref_last  [NUM_SLICES];
logic [31:0] ref_phys  [NUM_SLICES];

// Expected master-side pieces and miss reports, oldest first
rab_types_pkg::rab_req_t  exp_m    [$];
rab_types_pkg::rab_miss_t exp_miss [$];

// Lowest enabled slice holding the address, -1 on a miss
function automatic int find_slice(input logic [31:0] addr);
  for (int i = 0; i < NUM_SLICES; i++)
  begin
    if (ref_en[i] && (addr >= ref_first[i]) && (addr <= ref_last[i]))
    begin
      return i;
    end
  end
  return -1;
endfunction

// Queues what one accepted request must produce
task automatic expect_request(input logic [31:0] addr, input logic [3:0] id,
                              input logic [7:0] len);
  int                       idx;
  int                       beats;
  int                       room;
  int                       n;
  logic [31:0]              a;
  rab_types_pkg::rab_req_t  piece;
  rab_types_pkg::rab_miss_t report;
  idx = find_slice(addr);
  if (idx < 0)
  begin
    // Miss keeps the untranslated address
    report.addr = addr;
    report.id   = id;
    exp_miss.push_back(report);
  end
  else
  begin
    a     = ref_phys[idx] + (addr - ref_first[idx]);
    beats = len + 1;
    while (beats > 0)
    begin
      // 512 beats of 8 bytes per 4 KiB page
      room       = 512 - a[11:3];
      n          = (beats < room) ? beats : room;
      piece.addr = a;
      piece.id   = id;
      piece.len  = 8'(n - 1);
      exp_m.push_back(piece);
      a     = a + n * 8;
      beats = beats - n;
    end
  end
endtask

// Newest entries lost to a flush
task automatic drop_newest_pieces(input int n);
  rab_types_pkg::rab_req_t gone;
  repeat (n)
  begin
    gone = exp_m.pop_back();
  end
endtask

task automatic drop_newest_misses(input int n);
  rab_types_pkg::rab_miss_t gone;
  repeat (n)
  begin
    gone = exp_miss.pop_back();
  end
endtask

`endif

// File: tb/tb_rab_addr_path.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rab_addr_path;

  localparam int NUM_SLICES = 4;
  localparam int REQ_DEPTH  = 16;
  localparam int MISS_DEPTH = 8;

  // Requests sent per test
  localparam int N_T1 = 8;
  localparam int N_T2 = 7;
  localparam int N_T3 = 6;
  // Fills the miss FIFO, then the splitter, the request FIFO and the lookup stage
  localparam int N_FILL = MISS_DEPTH + REQ_DEPTH + 2;
  localparam int N_T4 = 200;
  localparam int N_T5 = 14;
  localparam int TOTAL_REQS      = N_T1 + N_T2 + N_T3 + N_FILL + N_T4 + N_T5;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 64 + 1000;

  logic        clk;
  logic        rstn;
  logic        flush;
  logic        cfg_we;
  logic [1:0]  cfg_idx;
  logic        cfg_en;
  logic [31:0] cfg_first;
  logic [31:0] cfg_last;
  logic [31:0] cfg_phys;
  logic        in_valid;
  logic [31:0] in_addr;
  logic [3:0]  in_id;
  logic [7:0]  in_len;
  logic        in_ready;
  logic        m_valid;
  logic [31:0] m_addr;
  logic [3:0]  m_id;
  logic [7:0]  m_len;
  logic        m_ready;
  logic        miss_valid;
  logic [31:0] miss_addr;
  logic [3:0]  miss_id;
  logic        miss_ready;

  int errors;
  int checks;
  int test_err_base;
  int tests_run;
  int tests_ok;

  // Random stimulus and back-pressure state
  logic [31:0] stim_lfsr;
  logic [31:0] bp_lfsr;
  logic [31:0] bp_bits;
  logic        bp_on;
  int          bp_cycle;
  logic [31:0] r_sel;
  logic [31:0] r_offs;
  logic [31:0] r_len;
  logic [31:0] r_big;
  logic [31:0] r_id;
  logic [31:0] r_gap;
  logic [31:0] base;

  rab_types_pkg::rab_req_t  want_m;
  rab_types_pkg::rab_miss_t want_miss;

  `include "tb_rab_ref.svh"

  rab_addr_path #(
    .NUM_SLICES ( NUM_SLICES ),
    .REQ_DEPTH  ( REQ_DEPTH  ),
    .MISS_DEPTH ( MISS_DEPTH )
  ) i_dut (
    .clk        ( clk        ),
    .rstn       ( rstn       ),
    .flush      ( flush      ),
    .cfg_we     ( cfg_we     ),
    .cfg_idx    ( cfg_idx    ),
    .cfg_en     ( cfg_en     ),
    .cfg_first  ( cfg_first  ),
    .cfg_last   ( cfg_last   ),
    .cfg_phys   ( cfg_phys   ),
    .in_valid   ( in_valid   ),
    .in_addr    ( in_addr    ),
    .in_id      ( in_id      ),
    .in_len     ( in_len     ),
    .in_ready   ( in_ready   ),
    .m_valid    ( m_valid    ),
    .m_addr     ( m_addr     ),
    .m_id       ( m_id       ),
    .m_len      ( m_len      ),
    .m_ready    ( m_ready    ),
    .miss_valid ( miss_valid ),
    .miss_addr  ( miss_addr  ),
    .miss_id    ( miss_id    ),
    .miss_ready ( miss_ready )
  );

  // 40 ns clock
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // Random source
  // ----------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, inout logic [31:0] state, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      state = lfsr_next(state);
      val   = {val[30:0], state[0]};
    end
  endtask

  // Random ready with periodic stall windows so both FIFOs fill up
  always @(posedge clk)
  begin
    #2;
    if (bp_on)
    begin
      if ((bp_cycle % 80) < 30)
      begin
        m_ready    = 1'b0;
        miss_ready = 1'b0;
      end
      else
      begin
        draw(2, bp_lfsr, bp_bits);
        m_ready = |bp_bits[1:0];
        draw(2, bp_lfsr, bp_bits);
        miss_ready = |bp_bits[1:0];
      end
      bp_cycle++;
    end
  end

  // ----------------------------------------
  // Comparison of every output transfer
  // ----------------------------------------
  // Sampled mid-cycle, inputs only change just after the rising edge
  always @(negedge clk)
  begin
    if (rstn && m_valid && m_ready)
    begin
      checks++;
      assert (exp_m.size() != 0)
      else
      begin
        $display("Unexpected master transfer at %0t, addr %h id %0d, nothing was due",
                 $time, m_addr, m_id);
        errors++;
      end
      if (exp_m.size() != 0)
      begin
        want_m = exp_m.pop_front();
        assert (m_addr == want_m.addr && m_id == want_m.id && m_len == want_m.len)
        else
        begin
          $display("MISMATCH at %0t: piece addr %h id %0d len %0d, expected %h %0d %0d",
                   $time, m_addr, m_id, m_len, want_m.addr, want_m.id, want_m.len);
          errors++;
        end
      end
    end
    if (rstn && miss_valid && miss_ready)
    begin
      checks++;
      assert (exp_miss.size() != 0)
      else
      begin
        $display("Unexpected miss report at %0t, addr %h id %0d, nothing was due",
                 $time, miss_addr, miss_id);
        errors++;
      end
      if (exp_miss.size() != 0)
      begin
        want_miss = exp_miss.pop_front();
        assert (miss_addr == want_miss.addr && miss_id == want_miss.id)
        else
        begin
          $display("MISMATCH at %0t: miss addr %h id %0d, expected %h %0d",
                   $time, miss_addr, miss_id, want_miss.addr, want_miss.id);
          errors++;
        end
      end
    end
  end

  // Bounds the whole run
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------
  // Drivers, all start and end 2 ns after a rising edge
  // ----------------------------------------
  task automatic apply_reset();
    rstn = 1'b0;
    // Slice enables clear on reset
    for (int i = 0; i < NUM_SLICES; i++)
    begin
      ref_en[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #2;
    rstn = 1'b1;
  endtask

  task automatic write_slice(input int idx, input logic en, input logic [31:0] first,
                             input logic [31:0] last, input logic [31:0] phys);
    cfg_we         = 1'b1;
    cfg_idx        = idx[1:0];
    cfg_en         = en;
    cfg_first      = first;
    cfg_last       = last;
    cfg_phys       = phys;
    ref_en[idx]    = en;
    ref_first[idx] = first;
    ref_last[idx]  = last;
    ref_phys[idx]  = phys;
    @(posedge clk);
    #2;
    cfg_we = 1'b0;
  endtask

  // Slice 1 overlaps slice 0, slice 2 is disabled
  // Slice 3 maps to a base off the page grid
  task automatic setup_slices();
    write_slice(0, 1'b1, 32'h0001_0000, 32'h0001_ffff, 32'h8000_0000);
    write_slice(1, 1'b1, 32'h0001_8000, 32'h0002_7fff, 32'h9000_0000);
    write_slice(2, 1'b0, 32'h0004_0000, 32'h0004_ffff, 32'ha000_0000);
    write_slice(3, 1'b1, 32'h0010_0000, 32'h001f_ffff, 32'h7000_0a00);
  endtask

  // Holds the request until the DUT takes it
  task automatic send_req(input logic [31:0] addr, input logic [3:0] id,
                          input logic [7:0] len);
    in_valid = 1'b1;
    in_addr  = addr;
    in_id    = id;
    in_len   = len;
    @(negedge clk);
    while (!in_ready)
    begin
      @(negedge clk);
    end
    expect_request(addr, id, len);
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while ((exp_m.size() != 0 || exp_miss.size() != 0) && cyc < 2000)
    begin
      @(posedge clk);
      cyc++;
    end
    // Quiet period catches extra transfers
    repeat (10) @(posedge clk);
    #2;
    assert (exp_m.size() == 0 && exp_miss.size() == 0)
    else
    begin
      $display("Expected transfers never arrived: %0d pieces and %0d misses left at %0t",
               exp_m.size(), exp_miss.size(), $time);
      errors++;
    end
  endtask

  task automatic end_test(input int num, input string name, input int reqs);
    tests_run++;
    if (errors == test_err_base)
    begin
      tests_ok++;
      $display("Test %0d %s: ok, %0d requests", num, name, reqs);
    end
    else
    begin
      $display("Test %0d %s: FAILED with %0d errors", num, name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    rstn       = 1'b0;
    flush      = 1'b0;
    cfg_we     = 1'b0;
    cfg_idx    = '0;
    cfg_en     = 1'b0;
    cfg_first  = '0;
    cfg_last   = '0;
    cfg_phys   = '0;
    in_valid   = 1'b0;
    in_addr    = '0;
    in_id      = '0;
    in_len     = '0;
    m_ready    = 1'b1;
    miss_ready = 1'b1;
    bp_on      = 1'b0;
    bp_cycle   = 0;
    stim_lfsr  = 32'he9ef;
    bp_lfsr    = 32'he9ef;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    tests_ok   = 0;
    test_err_base = 0;

    apply_reset();
    setup_slices();

    // Single beats, overlap region resolves to slice 0
    send_req(32'h0001_0000, 4'h1, 8'd0);
    send_req(32'h0001_7ff8, 4'h2, 8'd0);
    send_req(32'h0001_8000, 4'h3, 8'd0);
    send_req(32'h0001_fff8, 4'h4, 8'd0);
    send_req(32'h0002_0000, 4'h5, 8'd0);
    send_req(32'h0002_7ff8, 4'h6, 8'd0);
    send_req(32'h0010_0000, 4'h7, 8'd0);
    send_req(32'h001f_fff8, 4'h8, 8'd0);
    wait_drain();
    end_test(1, "hit translation", N_T1);

    // Outside every range, or inside the disabled slice
    send_req(32'h0000_0000, 4'h1, 8'd0);
    send_req(32'h0000_fff8, 4'h2, 8'd3);
    send_req(32'h0002_8000, 4'h3, 8'd0);
    send_req(32'h0004_0000, 4'h4, 8'd7);
    send_req(32'h0004_fff8, 4'h5, 8'd0);
    send_req(32'h0030_0000, 4'h6, 8'd15);
    send_req(32'hffff_fff8, 4'h7, 8'd0);
    wait_drain();
    end_test(2, "misses", N_T2);

    // Physical starts at 0xff8, 0xf00, 0x1000, 0x1808, 0x1ff8 and 0x80000ff0
    send_req(32'h0010_05f8, 4'h9, 8'd1);
    send_req(32'h0010_0500, 4'ha, 8'd63);
    send_req(32'h0010_0600, 4'hb, 8'd255);
    send_req(32'h0010_0e08, 4'hc, 8'd255);
    send_req(32'h0010_15f8, 4'hd, 8'd255);
    send_req(32'h0001_0ff0, 4'he, 8'd3);
    wait_drain();
    end_test(3, "page splitting", N_T3);

    // Misses first, then hits until the lookup stage holds one that cannot leave
    m_ready    = 1'b0;
    miss_ready = 1'b0;
    for (int i = 0; i < MISS_DEPTH; i++)
    begin
      send_req(32'h0030_0200 + i * 8, 4'(i), 8'd0);
    end
    for (int i = 0; i < REQ_DEPTH + 2; i++)
    begin
      send_req(32'h0001_4000 + i * 8, 4'(i), 8'd0);
    end
    assert (!in_ready)
    else
    begin
      $display("Lookup still accepts requests with both FIFOs full at %0t", $time);
      errors++;
    end
    m_ready    = 1'b1;
    miss_ready = 1'b1;

    bp_on = 1'b1;
    for (int i = 0; i < N_T4; i++)
    begin
      draw(3, stim_lfsr, r_sel);
      draw(16, stim_lfsr, r_offs);
      draw(8, stim_lfsr, r_len);
      draw(1, stim_lfsr, r_big);
      draw(4, stim_lfsr, r_id);
      draw(1, stim_lfsr, r_gap);
      // Regions cover every slice, the disabled one and unmapped space
      case (r_sel[2:0])
        3'd0: base = 32'h0001_0000;
        3'd1: base = 32'h0001_8000;
        3'd2: base = 32'h0010_0000;
        3'd3: base = 32'h0004_0000;
        3'd4: base = 32'h0030_0000;
        3'd5: base = 32'h0002_0000;
        3'd6: base = 32'h0010_0f00;
        default: base = 32'hffff_0000;
      endcase
      send_req(base + {r_offs[15:3], 3'b000}, r_id[3:0],
               r_big[0] ? r_len[7:0] : {4'h0, r_len[3:0]});
      if (!r_gap[0])
      begin
        @(posedge clk);
        #2;
      end
    end
    bp_on      = 1'b0;
    m_ready    = 1'b1;
    miss_ready = 1'b1;
    wait_drain();
    end_test(4, "random mix with back-pressure", N_FILL + N_T4);

    // Leave a hit in the splitter and a miss in its FIFO for the reset to clear
    m_ready    = 1'b0;
    miss_ready = 1'b0;
    send_req(32'h0001_0200, 4'h1, 8'd0);
    send_req(32'h0030_0100, 4'h2, 8'd0);
    repeat (4) @(posedge clk);
    #2;
    apply_reset();
    exp_m.delete();
    exp_miss.delete();
    assert (in_ready && !m_valid && !miss_valid)
    else
    begin
      $display("Wrong state after reset: in_ready %b m_valid %b miss_valid %b",
               in_ready, m_valid, miss_valid);
      errors++;
    end
    setup_slices();
    m_ready    = 1'b0;
    miss_ready = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      send_req(32'h0001_0100 + i * 8, 4'(i), 8'd0);
    end
    for (int i = 0; i < 3; i++)
    begin
      send_req(32'h0030_0000 + i * 8, 4'(8 + i), 8'd0);
    end
    repeat (4) @(posedge clk);
    #2;
    // Splitter holds the first hit, the request FIFO the other three
    // Single beats, so one piece per hit
    drop_newest_pieces(3);
    drop_newest_misses(3);
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
    assert (m_valid && !miss_valid)
    else
    begin
      $display("Flush affected the wrong state: m_valid %b miss_valid %b at %0t",
               m_valid, miss_valid, $time);
      errors++;
    end
    m_ready    = 1'b1;
    miss_ready = 1'b1;
    for (int i = 0; i < 3; i++)
    begin
      send_req(32'h0010_0040 + i * 8, 4'(4 + i), 8'd1);
    end
    send_req(32'h0004_0008, 4'hb, 8'd0);
    send_req(32'h0000_0008, 4'hc, 8'd0);
    wait_drain();
    end_test(5, "flush and reset state", N_T5);

    $display("Tests run %0d, ok %0d, failing %0d, transfers checked %0d, errors %0d",
             tests_run, tests_ok, tests_run - tests_ok, checks, errors);
    if (errors == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+tb
logic/rab_cfg_pkg.sv
logic/rab_types_pkg.sv
logic/rab_stream_if.sv
logic/rab_bram.sv
logic/rab_fifo_bram.sv
logic/rab_slice_lookup.sv
logic/rab_burst_split.sv
logic/rab_addr_path.sv
tb/tb_rab_addr_path.sv

// File: Bender.yml
package:
  name: rab_addr_path

sources:
  - logic/rab_cfg_pkg.sv
  - logic/rab_types_pkg.sv
  - logic/rab_stream_if.sv
  - logic/rab_bram.sv
  - logic/rab_fifo_bram.sv
  - logic/rab_slice_lookup.sv
  - logic/rab_burst_split.sv
  - logic/rab_addr_path.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_rab_addr_path.sv
